/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tcp_engine_tb
FILELIST  = tcp_engine.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^=== PASS ===$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* hw/rr_sched.sv */
`timescale 1ns/1ps
`include "tcp_config.svh"

module rr_sched
import tcp_pkg::*;
(
     input  logic       clk
    ,input  logic       reset

    ,input  flow_mask_t pending
    ,input  logic       grant_take

    ,output logic       grant_val
    ,output flowid_t    grant_flowid
);

    flowid_t    last_q;

    // Search starts one past the last served flow.
    always_comb begin
        flowid_t cand;

        grant_val    = 1'b0;
        grant_flowid = last_q;
        for (int k = 1; k <= `FLOW_CNT; k++) begin
            cand = flowid_t'((int'(last_q) + k) % `FLOW_CNT);
            if (!grant_val && pending[cand]) begin
                grant_val    = 1'b1;
                grant_flowid = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_q <= flowid_t'(`FLOW_CNT - 1);   // Flow 0 goes first.
        end else if (grant_take) begin
            last_q <= grant_flowid;
        end
    end

endmodule

/* hw/rx_seq_tracker.sv */
`timescale 1ns/1ps
`include "tcp_config.svh"

module rx_seq_tracker
import tcp_pkg::*;
(
     input  logic       clk
    ,input  logic       reset

    ,input  logic       flow_open
    ,input  logic       seq_check
    ,input  flowid_t    trk_flowid
    ,input  seq_t       trk_seq
    ,input  len_t       trk_len

    ,output logic       rx_open
    ,output seq_t       rx_expected
    ,output logic       rx_accept
);

    flow_mask_t open_q;
    seq_t       expected_q [`FLOW_CNT];
    logic       in_order;

    assign rx_open     = open_q[trk_flowid];
    assign rx_expected = expected_q[trk_flowid];

    // Empty segments never advance the window.
    assign in_order = (trk_seq == expected_q[trk_flowid]) && (trk_len != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            open_q    <= '0;
            rx_accept <= 1'b0;
        end else begin
            if (flow_open) begin
                open_q[trk_flowid] <= 1'b1;
            end
            if (seq_check) begin
                rx_accept <= in_order;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flow_open) begin
            expected_q[trk_flowid] <= trk_seq + 1'b1;   // SYN uses one number.
        end else if (seq_check && in_order) begin
            expected_q[trk_flowid] <= expected_q[trk_flowid] + seq_t'(trk_len);
        end
    end

endmodule

/* hw/tcp_config.svh */
`ifndef TCP_CONFIG_SVH
`define TCP_CONFIG_SVH

// Flow table size.
`define FLOW_CNT    4
`define FLOWID_W    2

// Header field widths.
`define SEQ_W       32
`define LEN_W       16
`define FLAGS_W     8

// Flag bit positions in the TCP flag byte.
`define FLAG_SYN    1
`define FLAG_PSH    3
`define FLAG_ACK    4

`define MAX_SEG     64  // Payload bytes per segment.
`define TX_Q_DEPTH  2

`endif

/* hw/tcp_ctrl.sv */
`timescale 1ns/1ps
`include "tcp_config.svh"

module tcp_ctrl
import tcp_pkg::*;
(
     input  logic           clk
    ,input  logic           reset

    ,input  logic           rx_hdr_val
    ,output logic           rx_hdr_rdy
    ,input  flowid_t        rx_flowid
    ,input  seq_t           rx_seq
    ,input  len_t           rx_len
    ,input  tcp_flags_t     rx_flags

    ,output logic           rx_dst_val
    ,output flowid_t        rx_dst_flowid
    ,output logic           rx_dst_accept
    ,input  logic           rx_dst_rdy

    ,output logic           app_new_flow_val
    ,output flowid_t        app_new_flow_flowid
    ,input  logic           app_new_flow_rdy

    ,output logic           flow_open
    ,output logic           seq_check
    ,output flowid_t        trk_flowid
    ,output seq_t           trk_seq
    ,output len_t           trk_len
    ,input  logic           rx_open
    ,input  seq_t           rx_expected
    ,input  logic           rx_accept

    ,output logic           tx_reset
    ,output logic           tx_take
    ,output flowid_t        tx_flowid
    ,input  seq_t           tx_head
    ,input  len_t           tx_seg_len

    ,input  logic           grant_val
    ,input  flowid_t        grant_flowid
    ,output logic           grant_take

    ,output logic           q_push
    ,output flowid_t        q_flowid
    ,output seq_t           q_seq
    ,output seq_t           q_ack
    ,output len_t           q_len
    ,output tcp_flags_t     q_flags
    ,input  logic           q_ready
);

    ctrl_state_e    state;
    ctrl_state_e    state_next;

    flowid_t        hdr_flowid;
    seq_t           hdr_seq;
    len_t           hdr_len;
    logic           hdr_syn;
    logic           res_accept;

    flowid_t        cur_flowid;
    logic           tx_go;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (rx_hdr_val) begin
                    state_next = RX_CHECK;
                end else if (grant_val) begin
                    state_next = TX_SEG;
                end
            end
            RX_CHECK: state_next = (hdr_syn || rx_open) ? RX_ACK : RX_NOTIFY;
            RX_ACK: begin
                if (q_ready) begin
                    state_next = RX_NOTIFY;
                end
            end
            RX_NOTIFY: begin
                if (hdr_syn ? app_new_flow_rdy : rx_dst_rdy) begin
                    state_next = IDLE;
                end
            end
            TX_SEG: begin
                // Grant may vanish if a tail write empties the flow.
                if (!grant_val || q_ready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_hdr_val && rx_hdr_rdy) begin
            hdr_flowid <= rx_flowid;
            hdr_seq    <= rx_seq;
            hdr_len    <= rx_len;
            hdr_syn    <= rx_flags[`FLAG_SYN];
        end
        if (state == RX_CHECK) begin
            res_accept <= 1'b0;       // Closed flow result.
        end else if (state == RX_ACK) begin
            res_accept <= rx_accept;
        end
    end

    assign rx_hdr_rdy = (state == IDLE);

    // The granted flow drives both trackers while sending.
    assign cur_flowid = (state == TX_SEG) ? grant_flowid : hdr_flowid;
    assign trk_flowid = cur_flowid;
    assign tx_flowid  = cur_flowid;
    assign trk_seq    = hdr_seq;
    assign trk_len    = hdr_len;

    assign flow_open = (state == RX_CHECK) && hdr_syn;
    assign tx_reset  = (state == RX_CHECK) && hdr_syn;
    assign seq_check = (state == RX_CHECK) && !hdr_syn && rx_open;

    assign tx_go      = (state == TX_SEG) && grant_val && q_ready;
    assign tx_take    = tx_go;
    assign grant_take = tx_go;

    // Head is zero right after a SYN, so SYN-ACKs go out with seq 0.
    assign q_push   = ((state == RX_ACK) && q_ready) || tx_go;
    assign q_flowid = cur_flowid;
    assign q_seq    = tx_head;
    assign q_ack    = rx_expected;
    assign q_len    = (state == TX_SEG) ? tx_seg_len : '0;

    always_comb begin
        q_flags = '0;
        q_flags[`FLAG_ACK] = 1'b1;
        if (state == TX_SEG) begin
            q_flags[`FLAG_PSH] = 1'b1;
        end else if (hdr_syn) begin
            q_flags[`FLAG_SYN] = 1'b1;
        end
    end

    assign rx_dst_val          = (state == RX_NOTIFY) && !hdr_syn;
    assign rx_dst_flowid       = hdr_flowid;
    assign rx_dst_accept       = res_accept;
    assign app_new_flow_val    = (state == RX_NOTIFY) && hdr_syn;
    assign app_new_flow_flowid = hdr_flowid;

    // Transmit head of a freshly opened flow is cleared before its SYN-ACK.
    syn_ack_head: assert property (@(posedge clk) disable iff (reset)
        (state == RX_ACK) && hdr_syn |-> tx_head == '0);

endmodule

/* hw/tcp_engine.sv */
`timescale 1ns/1ps

module tcp_engine
import tcp_pkg::*;
(
     input  logic           clk
    ,input  logic           reset

    ,input  logic           rx_hdr_val
    ,output logic           rx_hdr_rdy
    ,input  flowid_t        rx_flowid
    ,input  seq_t           rx_seq
    ,input  len_t           rx_len
    ,input  tcp_flags_t     rx_flags

    ,output logic           rx_dst_val
    ,output flowid_t        rx_dst_flowid
    ,output logic           rx_dst_accept
    ,input  logic           rx_dst_rdy

    ,output logic           app_new_flow_val
    ,output flowid_t        app_new_flow_flowid
    ,input  logic           app_new_flow_rdy

    ,input  logic           app_tx_tail_val
    ,input  flowid_t        app_tx_tail_flowid
    ,input  seq_t           app_tx_tail_ptr

    ,output logic           tx_pkt_val
    ,output flowid_t        tx_pkt_flowid
    ,output seq_t           tx_pkt_seq
    ,output seq_t           tx_pkt_ack
    ,output len_t           tx_pkt_len
    ,output tcp_flags_t     tx_pkt_flags
    ,input  logic           tx_pkt_rdy
);

    // Receive sequence tracker.
    logic           flow_open;
    logic           seq_check;
    flowid_t        trk_flowid;
    seq_t           trk_seq;
    len_t           trk_len;
    logic           rx_open;
    seq_t           rx_expected;
    logic           rx_accept;

    // Transmit pointers and scheduler.
    logic           tx_reset;
    logic           tx_take;
    flowid_t        tx_flowid;
    seq_t           tx_head;
    len_t           tx_seg_len;
    flow_mask_t     pending;
    logic           grant_val;
    flowid_t        grant_flowid;
    logic           grant_take;

    // Output header queue.
    logic           q_push;
    flowid_t        q_flowid;
    seq_t           q_seq;
    seq_t           q_ack;
    len_t           q_len;
    tcp_flags_t     q_flags;
    logic           q_ready;

    // Port and wire names line up across the tree.
    tcp_ctrl        tcp_ctrl_i       (.*);
    rx_seq_tracker  rx_seq_tracker_i (.*);
    tx_seg_tracker  tx_seg_tracker_i (.*);
    rr_sched        rr_sched_i       (.*);
    tx_pkt_queue    tx_pkt_queue_i   (.*);

endmodule

/* hw/tcp_pkg.sv */
`include "tcp_config.svh"

package tcp_pkg;

    typedef logic [`FLOWID_W-1:0]   flowid_t;

    // Sequence numbers and byte pointers share one width.
    typedef logic [`SEQ_W-1:0]      seq_t;

    typedef logic [`LEN_W-1:0]      len_t;
    typedef logic [`FLAGS_W-1:0]    tcp_flags_t;
    typedef logic [`FLOW_CNT-1:0]   flow_mask_t;   // One bit per flow.

    typedef enum logic [2:0] {
        IDLE,
        RX_CHECK,
        RX_ACK,
        RX_NOTIFY,
        TX_SEG
    } ctrl_state_e;

endpackage

/* hw/tx_pkt_queue.sv */
`timescale 1ns/1ps
`include "tcp_config.svh"

module tx_pkt_queue
import tcp_pkg::*;
(
     input  logic       clk
    ,input  logic       reset

    ,input  logic       q_push
    ,input  flowid_t    q_flowid
    ,input  seq_t       q_seq
    ,input  seq_t       q_ack
    ,input  len_t       q_len
    ,input  tcp_flags_t q_flags
    ,output logic       q_ready

    ,output logic       tx_pkt_val
    ,output flowid_t    tx_pkt_flowid
    ,output seq_t       tx_pkt_seq
    ,output seq_t       tx_pkt_ack
    ,output len_t       tx_pkt_len
    ,output tcp_flags_t tx_pkt_flags
    ,input  logic       tx_pkt_rdy
);

    localparam int PTR_W = $clog2(`TX_Q_DEPTH);
    localparam int CNT_W = $clog2(`TX_Q_DEPTH + 1);

    flowid_t    flowid_mem [`TX_Q_DEPTH];
    seq_t       seq_mem    [`TX_Q_DEPTH];
    seq_t       ack_mem    [`TX_Q_DEPTH];
    len_t       len_mem    [`TX_Q_DEPTH];
    tcp_flags_t flags_mem  [`TX_Q_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign q_ready    = (count != CNT_W'(`TX_Q_DEPTH));
    assign tx_pkt_val = (count != '0);
    assign do_push    = q_push && q_ready;
    assign do_pop     = tx_pkt_val && tx_pkt_rdy;

    assign tx_pkt_flowid = flowid_mem[rd_ptr];
    assign tx_pkt_seq    = seq_mem[rd_ptr];
    assign tx_pkt_ack    = ack_mem[rd_ptr];
    assign tx_pkt_len    = len_mem[rd_ptr];
    assign tx_pkt_flags  = flags_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`TX_Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`TX_Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            flowid_mem[wr_ptr] <= q_flowid;
            seq_mem[wr_ptr]    <= q_seq;
            ack_mem[wr_ptr]    <= q_ack;
            len_mem[wr_ptr]    <= q_len;
            flags_mem[wr_ptr]  <= q_flags;
        end
    end

    // A stalled header must not change before the egress takes it.
    egress_hold: assert property (@(posedge clk) disable iff (reset)
        tx_pkt_val && !tx_pkt_rdy |=> tx_pkt_val && $stable(tx_pkt_flowid)
            && $stable(tx_pkt_seq) && $stable(tx_pkt_ack)
            && $stable(tx_pkt_len) && $stable(tx_pkt_flags));

endmodule

/* hw/tx_seg_tracker.sv */
`timescale 1ns/1ps
`include "tcp_config.svh"

module tx_seg_tracker
import tcp_pkg::*;
(
     input  logic       clk
    ,input  logic       reset

    ,input  logic       tx_reset
    ,input  logic       tx_take
    ,input  flowid_t    tx_flowid

    ,input  logic       app_tx_tail_val
    ,input  flowid_t    app_tx_tail_flowid
    ,input  seq_t       app_tx_tail_ptr

    ,output seq_t       tx_head
    ,output len_t       tx_seg_len
    ,output flow_mask_t pending
);

    seq_t   head_q [`FLOW_CNT];
    seq_t   tail_q [`FLOW_CNT];
    seq_t   unsent;

    assign tx_head = head_q[tx_flowid];
    assign unsent  = tail_q[tx_flowid] - head_q[tx_flowid];

    assign tx_seg_len = (unsent > seq_t'(`MAX_SEG)) ? len_t'(`MAX_SEG) : len_t'(unsent);

    always_comb begin
        for (int i = 0; i < `FLOW_CNT; i++) begin
            pending[i] = (head_q[i] != tail_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FLOW_CNT; i++) begin
                head_q[i] <= '0;
                tail_q[i] <= '0;
            end
        end else begin
            if (tx_reset) begin
                head_q[tx_flowid] <= '0;
                tail_q[tx_flowid] <= '0;
            end else if (tx_take) begin
                head_q[tx_flowid] <= head_q[tx_flowid] + seq_t'(tx_seg_len);
            end
            // Tail write lands even alongside a take on the same flow.
            if (app_tx_tail_val) begin
                tail_q[app_tx_tail_flowid] <= app_tx_tail_ptr;
            end
        end
    end

    take_pending: assert property (@(posedge clk) disable iff (reset)
        tx_take |-> pending[tx_flowid]);

endmodule

/* tcp_engine.f */
+incdir+hw
hw/tcp_pkg.sv
hw/rx_seq_tracker.sv
hw/tx_seg_tracker.sv
hw/rr_sched.sv
hw/tx_pkt_queue.sv
hw/tcp_ctrl.sv
hw/tcp_engine.sv
test/tcp_engine_checker.sv
test/tcp_engine_tb.sv

/* test/tcp_engine_checker.sv */
`timescale 1ns/1ps
`include "tcp_config.svh"

module tcp_engine_checker
import tcp_pkg::*;
(
     input  logic           clk
    ,input  logic           reset
    ,input  logic [127:0]   test_name
    ,input  logic           exp_accept

    ,input  logic           rx_hdr_val
    ,input  logic           rx_hdr_rdy
    ,input  flowid_t        rx_flowid
    ,input  seq_t           rx_seq
    ,input  len_t           rx_len
    ,input  tcp_flags_t     rx_flags

    ,input  logic           rx_dst_val
    ,input  flowid_t        rx_dst_flowid
    ,input  logic           rx_dst_accept
    ,input  logic           rx_dst_rdy
    ,input  logic           app_new_flow_val
    ,input  flowid_t        app_new_flow_flowid
    ,input  logic           app_new_flow_rdy

    ,input  logic           app_tx_tail_val
    ,input  flowid_t        app_tx_tail_flowid
    ,input  seq_t           app_tx_tail_ptr

    ,input  logic           tx_pkt_val
    ,input  flowid_t        tx_pkt_flowid
    ,input  seq_t           tx_pkt_seq
    ,input  seq_t           tx_pkt_ack
    ,input  len_t           tx_pkt_len
    ,input  tcp_flags_t     tx_pkt_flags
    ,input  logic           tx_pkt_rdy

    ,output int             busy
    ,output int             errors
    ,output int             checks
);

    localparam int HDR_W = `FLOWID_W + 2 * `SEQ_W + `LEN_W + `FLAGS_W;
    localparam tcp_flags_t F_SYN = tcp_flags_t'(1 << `FLAG_SYN);
    localparam tcp_flags_t F_ACK = tcp_flags_t'(1 << `FLAG_ACK);
    localparam tcp_flags_t F_PSH = tcp_flags_t'(1 << `FLAG_PSH);

    typedef logic [HDR_W-1:0] hdr_vec_t;   // {flow, seq, ack, len, flags}.

    hdr_vec_t           ctl_q [$];   // ACKs and SYN-ACKs in receive order.
    hdr_vec_t           data_q [$];
    logic [`FLOWID_W:0] res_q [$];   // {flow, accept}.
    flowid_t            new_q [$];

    logic       open_m [`FLOW_CNT];
    seq_t       exp_m  [`FLOW_CNT];
    seq_t       head_m [`FLOW_CNT];
    flowid_t    last_data;

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error [%0s] %0s: expected 0x%0h, actual 0x%0h",
                     test_name, what, exp, act);
        end
    endtask

    function automatic bit flow_waiting(input flowid_t g);
        bit found;
        found = 1'b0;
        foreach (data_q[i]) begin
            if (data_q[i][HDR_W-1 -: `FLOWID_W] == g) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic record_rx();
        flowid_t f;
        logic    in_order;
        f = rx_flowid;
        if (rx_flags[`FLAG_SYN]) begin
            open_m[f] = 1'b1;
            exp_m[f]  = rx_seq + 32'd1;
            head_m[f] = '0;
            ctl_q.push_back({f, seq_t'(0), exp_m[f], len_t'(0), F_SYN | F_ACK});
            new_q.push_back(f);
        end else if (open_m[f]) begin
            in_order = (rx_seq == exp_m[f]) && (rx_len != '0);
            if (in_order) begin
                exp_m[f] = exp_m[f] + seq_t'(rx_len);
            end
            ctl_q.push_back({f, head_m[f], exp_m[f], len_t'(0), F_ACK});
            res_q.push_back({f, exp_accept});
        end else begin
            res_q.push_back({f, exp_accept});   // No ACK on a closed flow.
        end
    endtask

    // Unsent bytes split into full segments and one remainder.
    task automatic record_tail();
        flowid_t f;
        seq_t    left;
        len_t    seg;
        f    = app_tx_tail_flowid;
        left = app_tx_tail_ptr - head_m[f];
        while (left != '0) begin
            seg = (left > seq_t'(`MAX_SEG)) ? len_t'(`MAX_SEG) : len_t'(left);
            data_q.push_back({f, head_m[f], exp_m[f], seg, F_ACK | F_PSH});
            head_m[f] = head_m[f] + seq_t'(seg);
            left      = left - seq_t'(seg);
        end
    endtask

    task automatic check_result();
        logic [`FLOWID_W:0] e;
        if (res_q.size() == 0) begin
            errors++;
            $display("Receive result for flow %0d in step %0s was not expected",
                     rx_dst_flowid, test_name);
        end else begin
            e = res_q.pop_front();
            compare_value("result flow", 32'(e[`FLOWID_W:1]), 32'(rx_dst_flowid));
            compare_value("result accept", 32'(e[0]), 32'(rx_dst_accept));
        end
    endtask

    task automatic check_new_flow();
        if (new_q.size() == 0) begin
            errors++;
            $display("New-flow notice for flow %0d in step %0s was not expected",
                     app_new_flow_flowid, test_name);
        end else begin
            compare_value("new flow id", 32'(new_q.pop_front()), 32'(app_new_flow_flowid));
        end
    endtask

    task automatic check_egress();
        hdr_vec_t   e;
        int         idx;
        flowid_t    g;
        flowid_t    e_flow;
        seq_t       e_seq;
        seq_t       e_ack;
        len_t       e_len;
        tcp_flags_t e_flags;
        idx = -1;
        if (tx_pkt_len == '0) begin
            if (ctl_q.size() != 0) begin
                e   = ctl_q.pop_front();
                idx = 0;
            end
        end else begin
            for (int i = data_q.size() - 1; i >= 0; i--) begin
                if (data_q[i][HDR_W-1 -: `FLOWID_W] == tx_pkt_flowid) begin
                    idx = i;   // Oldest entry of this flow.
                end
            end
            if (idx >= 0) begin
                // Flows between the last served one and this one must be empty.
                g = flowid_t'((int'(last_data) + 1) % `FLOW_CNT);
                while (g != tx_pkt_flowid) begin
                    if (flow_waiting(g)) begin
                        errors++;
                        $display("Round-robin order broken in step %0s: flow %0d passed over",
                                 test_name, g);
                    end
                    g = flowid_t'((int'(g) + 1) % `FLOW_CNT);
                end
                last_data = tx_pkt_flowid;
                e = data_q[idx];
                data_q.delete(idx);
            end
        end
        if (idx < 0) begin
            errors++;
            $display("Egress header on flow %0d with length %0d in step %0s was not expected",
                     tx_pkt_flowid, tx_pkt_len, test_name);
        end else begin
            {e_flow, e_seq, e_ack, e_len, e_flags} = e;
            compare_value("egress flow", 32'(e_flow), 32'(tx_pkt_flowid));
            compare_value("egress seq", e_seq, tx_pkt_seq);
            compare_value("egress ack", e_ack, tx_pkt_ack);
            compare_value("egress len", 32'(e_len), 32'(tx_pkt_len));
            compare_value("egress flags", 32'(e_flags), 32'(tx_pkt_flags));
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FLOW_CNT; i++) begin
                open_m[i] = 1'b0;
                head_m[i] = '0;
            end
            last_data = flowid_t'(`FLOW_CNT - 1);
            errors    = 0;
            checks    = 0;
        end else begin
            if (rx_hdr_val && rx_hdr_rdy) begin
                record_rx();
            end
            if (app_tx_tail_val) begin
                record_tail();
            end
            if (rx_dst_val && rx_dst_rdy) begin
                check_result();
            end
            if (app_new_flow_val && app_new_flow_rdy) begin
                check_new_flow();
            end
            if (tx_pkt_val && tx_pkt_rdy) begin
                check_egress();
            end
        end
        busy <= ctl_q.size() + data_q.size() + res_q.size() + new_q.size();
    end

endmodule

/* test/tcp_engine_tb.sv */
`timescale 1ns/1ps
`include "tcp_config.svh"

module tcp_engine_tb
import tcp_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 400;
    localparam tcp_flags_t F_SYN  = tcp_flags_t'(1 << `FLAG_SYN);
    localparam tcp_flags_t F_ACK  = tcp_flags_t'(1 << `FLAG_ACK);
    localparam tcp_flags_t F_DATA = tcp_flags_t'((1 << `FLAG_ACK) | (1 << `FLAG_PSH));

    typedef logic [127:0] name_t;

    logic       clk;
    logic       reset;
    logic       rx_hdr_val;
    logic       rx_hdr_rdy;
    flowid_t    rx_flowid;
    seq_t       rx_seq;
    len_t       rx_len;
    tcp_flags_t rx_flags;
    logic       rx_dst_val;
    flowid_t    rx_dst_flowid;
    logic       rx_dst_accept;
    logic       rx_dst_rdy;
    logic       app_new_flow_val;
    flowid_t    app_new_flow_flowid;
    logic       app_new_flow_rdy;
    logic       app_tx_tail_val;
    flowid_t    app_tx_tail_flowid;
    seq_t       app_tx_tail_ptr;
    logic       tx_pkt_val;
    flowid_t    tx_pkt_flowid;
    seq_t       tx_pkt_seq;
    seq_t       tx_pkt_ack;
    len_t       tx_pkt_len;
    tcp_flags_t tx_pkt_flags;
    logic       tx_pkt_rdy;

    name_t      test_name;
    logic       exp_accept;
    int         busy;
    int         errors;
    int         checks;
    bit         timed_out;
    integer     seed;

    // Stimulus table; the seq column holds the tail pointer for tail writes.
    name_t      step_name [$];
    bit         step_tail [$];
    flowid_t    step_flow [$];
    seq_t       step_seq [$];
    len_t       step_len [$];
    tcp_flags_t step_flags [$];
    bit         step_accept [$];
    bit         step_wait [$];

    tcp_engine tcp_engine_i (.*);
    tcp_engine_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        tx_pkt_rdy <= ($random(seed) % 4) != 0;   // Stalls about one cycle in four.
    end

    task automatic add_step(input name_t name, input bit tail, input flowid_t flow,
                            input seq_t seq, input len_t len, input tcp_flags_t flags,
                            input bit accept, input bit wait_done);
        step_name.push_back(name);
        step_tail.push_back(tail);
        step_flow.push_back(flow);
        step_seq.push_back(seq);
        step_len.push_back(len);
        step_flags.push_back(flags);
        step_accept.push_back(accept);
        step_wait.push_back(wait_done);
    endtask

    task automatic build_table();
        add_step("closed_seg", 1'b0, 2'd2, 32'd100, 16'd10, F_DATA, 1'b0, 1'b1);
        add_step("syn_f0", 1'b0, 2'd0, 32'd1000, 16'd0, F_SYN, 1'b0, 1'b1);
        add_step("syn_f1", 1'b0, 2'd1, 32'd2000, 16'd0, F_SYN, 1'b0, 1'b1);
        add_step("syn_f2", 1'b0, 2'd2, 32'd3000, 16'd0, F_SYN, 1'b0, 1'b1);
        add_step("syn_f3", 1'b0, 2'd3, 32'd4000, 16'd0, F_SYN, 1'b0, 1'b1);
        add_step("in_order", 1'b0, 2'd1, 32'd2001, 16'd20, F_DATA, 1'b1, 1'b1);
        add_step("out_of_order", 1'b0, 2'd1, 32'd2500, 16'd20, F_DATA, 1'b0, 1'b1);
        add_step("in_order_2", 1'b0, 2'd1, 32'd2021, 16'd30, F_DATA, 1'b1, 1'b1);
        add_step("zero_len", 1'b0, 2'd3, 32'd4001, 16'd0, F_ACK, 1'b0, 1'b1);
        add_step("tail_150", 1'b1, 2'd0, 32'd150, 16'd0, 8'd0, 1'b0, 1'b1);
        add_step("rr_f1", 1'b1, 2'd1, 32'd100, 16'd0, 8'd0, 1'b0, 1'b0);
        add_step("rr_f2", 1'b1, 2'd2, 32'd100, 16'd0, 8'd0, 1'b0, 1'b0);
        add_step("rr_f3", 1'b1, 2'd3, 32'd100, 16'd0, 8'd0, 1'b0, 1'b1);
        add_step("ack_after_tx", 1'b0, 2'd0, 32'd1001, 16'd8, F_DATA, 1'b1, 1'b1);
        add_step("tail_more", 1'b1, 2'd0, 32'd200, 16'd0, 8'd0, 1'b0, 1'b1);
    endtask

    task automatic wait_rx_taken();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rx_hdr_rdy && cycles < TIMEOUT_CYCLES);
        if (!rx_hdr_rdy) begin
            $display("Timeout: receive header of step %0s was never accepted", test_name);
            timed_out = 1'b1;
        end
    endtask

    // Waits until every expected packet and notice has been seen.
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (busy != 0 && cycles < TIMEOUT_CYCLES);
        if (busy != 0) begin
            $display("Timeout: %0d expected outputs of step %0s never arrived", busy, test_name);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        seed                = 93;
        timed_out           = 1'b0;
        reset               = 1'b1;
        rx_hdr_val          = 1'b0;
        rx_flowid           = '0;
        rx_seq              = '0;
        rx_len              = '0;
        rx_flags            = '0;
        rx_dst_rdy          = 1'b1;
        app_new_flow_rdy    = 1'b1;
        app_tx_tail_val     = 1'b0;
        app_tx_tail_flowid  = '0;
        app_tx_tail_ptr     = '0;
        tx_pkt_rdy          = 1'b1;
        test_name           = "reset";
        exp_accept          = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < step_name.size() && !timed_out; i++) begin
            test_name  <= step_name[i];
            exp_accept <= step_accept[i];
            if (step_tail[i]) begin
                app_tx_tail_val    <= 1'b1;
                app_tx_tail_flowid <= step_flow[i];
                app_tx_tail_ptr    <= step_seq[i];
                @(posedge clk);
                app_tx_tail_val <= 1'b0;
                if (step_wait[i]) begin
                    wait_drain();
                end
            end else begin
                rx_hdr_val <= 1'b1;
                rx_flowid  <= step_flow[i];
                rx_seq     <= step_seq[i];
                rx_len     <= step_len[i];
                rx_flags   <= step_flags[i];
                wait_rx_taken();
                rx_hdr_val <= 1'b0;
                if (!timed_out) begin
                    wait_drain();
                end
            end
        end
        repeat (10) @(posedge clk);   // Catch stray packets.
        $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
